/* design/bus_arbiter.sv */
/*
 * Fixed-priority bus arbiter for two masters.
 * Grants from idle on the next edge, master 1 first on a tie, and holds
 * the grant until the done pulse of the granted transfer. Grants are
 * decoded from the state register, so at most one is high.
 */

`timescale 1ns/1ns

module bus_arbiter import bus_pkg::*; (
    input  logic clk,
    input  logic rstn,
    input  logic breq1,
    input  logic breq2,
    input  logic done,      // Response routed to the granted master
    output logic bgrant1,
    output logic bgrant2
);

    arb_state_e state;
    arb_state_e state_nxt;

    // --------------------
    // Next state
    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (breq1) begin
                    state_nxt = ARB_M1;     // Master 1 wins ties
                end else if (breq2) begin
                    state_nxt = ARB_M2;
                end
            end
            ARB_M1, ARB_M2: begin
                if (done) begin
                    state_nxt = ARB_IDLE;   // Regrant possible one cycle later
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Grants straight off the state register
    assign bgrant1 = (state == ARB_M1);
    assign bgrant2 = (state == ARB_M2);

endmodule

/* design/bus_interconnect.sv */
/*
 * Bus interconnect for two masters and two memory slaves.
 * Picks the granted master's request, decodes the address against the map
 * in the package and strobes only the addressed slave with its local offset.
 * Unmapped accesses are answered here with zero data one cycle later.
 * Contains the arbiter, whose done is the response to the granted master.
 */

`timescale 1ns/1ns

module bus_interconnect import bus_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // Masters
    input  logic              m1_breq,
    input  logic              m2_breq,
    output logic              m1_bgrant,
    output logic              m2_bgrant,
    input  bus_req_t          m1_mreq,
    input  bus_req_t          m2_mreq,
    input  logic              m1_mvalid,
    input  logic              m2_mvalid,
    output logic              m1_svalid,
    output logic              m2_svalid,
    output logic [DATA_W-1:0] m1_rdata,
    output logic [DATA_W-1:0] m2_rdata,
    // Slaves
    output bus_req_t          s1_req,
    output bus_req_t          s2_req,
    output logic              s1_valid,
    output logic              s2_valid,
    input  logic              s1_svalid,
    input  logic              s2_svalid,
    input  logic [DATA_W-1:0] s1_rdata,
    input  logic [DATA_W-1:0] s2_rdata
);

    bus_req_t          req;         // Granted master's request
    logic              valid;
    logic [ADDR_W-1:0] s1_off;
    logic [ADDR_W-1:0] s2_off;
    logic              s1_hit;
    logic              s2_hit;
    logic              miss_svalid; // Own answer for unmapped addresses
    logic              resp_valid;
    logic [DATA_W-1:0] resp_data;

    bus_arbiter arb_inst (
        .clk     (clk),
        .rstn    (rstn),
        .breq1   (m1_breq),
        .breq2   (m2_breq),
        .done    (m1_svalid | m2_svalid),
        .bgrant1 (m1_bgrant),
        .bgrant2 (m2_bgrant)
    );

    // --------------------
    // Request path
    assign req   = m1_bgrant ? m1_mreq : m2_mreq;
    assign valid = (m1_bgrant && m1_mvalid) || (m2_bgrant && m2_mvalid);

    assign s1_off = req.addr - S1_BASE;
    assign s2_off = req.addr - S2_BASE;
    assign s1_hit = (s1_off[ADDR_W-1:S1_ADDR_W] == '0);          // Below 2 KB
    assign s2_hit = (req.addr >= S2_BASE) && (req.addr <= S2_LIMIT);

    always_comb begin
        s1_req      = req;
        s1_req.addr = s1_off;   // Local offsets to the slaves
        s2_req      = req;
        s2_req.addr = s2_off;
    end

    assign s1_valid = valid && s1_hit;
    assign s2_valid = valid && s2_hit;

    // Unmapped writes are dropped and unmapped reads get zero
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            miss_svalid <= 1'b0;
        end else begin
            miss_svalid <= valid && !s1_hit && !s2_hit;
        end
    end

    // --------------------
    // Response path
    assign resp_valid = s1_svalid || s2_svalid || miss_svalid;
    assign resp_data  = s1_svalid ? s1_rdata :
                        s2_svalid ? s2_rdata : '0;

    assign m1_svalid = m1_bgrant && resp_valid;
    assign m2_svalid = m2_bgrant && resp_valid;
    assign m1_rdata  = resp_data;   // Qualified by svalid
    assign m2_rdata  = resp_data;

endmodule

/* design/bus_pkg.sv */
/*
 * Shared definitions for the two-master, two-slave system bus.
 * Holds widths, the address map and the request and state types.
 * Every RTL file pulls this in with a wildcard import in its header.
 */

package bus_pkg;

    // --------------------
    // Widths
    localparam int ADDR_W    = 16;   // Bus address
    localparam int DATA_W    = 8;    // Byte wide data
    localparam int S1_ADDR_W = 11;   // 2 KB slave
    localparam int S2_ADDR_W = 12;   // 4 KB slave

    // --------------------
    // Address map
    localparam logic [ADDR_W-1:0] S1_BASE  = 16'h0000;
    localparam logic [ADDR_W-1:0] S2_BASE  = 16'h0800;
    localparam logic [ADDR_W-1:0] S2_LIMIT = 16'h17FF;  // Last byte of slave 2
    // Anything above S2_LIMIT is unmapped

    // Transfer direction
    typedef enum logic {
        MODE_READ  = 1'b0,
        MODE_WRITE = 1'b1
    } bus_mode_e;

    // One transfer, device side and bus side alike (25 bits)
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;   // Ignored on reads
        bus_mode_e         mode;
    } bus_req_t;

    // Arbiter FSM states
    typedef enum logic [1:0] {
        ARB_IDLE = 2'd0,
        ARB_M1   = 2'd1,
        ARB_M2   = 2'd2
    } arb_state_e;

endpackage

/* design/bus_system_top.sv */
/*
 * Top level of the two-master, two-slave system bus.
 * Wires two master ports, the interconnect with its arbiter, a 2 KB slave
 * at 0x0000 and a 4 KB slave at 0x0800. The device ports of both masters
 * and the two grant lines are brought out.
 */

`timescale 1ns/1ns

module bus_system_top import bus_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // Device ports
    input  bus_req_t          m1_req,
    input  bus_req_t          m2_req,
    input  logic              m1_dvalid,
    input  logic              m2_dvalid,
    output logic [DATA_W-1:0] m1_drdata,
    output logic [DATA_W-1:0] m2_drdata,
    output logic              m1_dready,
    output logic              m2_dready,
    // Status
    output logic              m1_bgrant,
    output logic              m2_bgrant
);

    // --------------------
    // Master to interconnect
    logic              m1_breq,   m2_breq;
    bus_req_t          m1_mreq,   m2_mreq;
    logic              m1_mvalid, m2_mvalid;
    logic              m1_svalid, m2_svalid;
    logic [DATA_W-1:0] m1_rdata,  m2_rdata;

    // Interconnect to slaves
    bus_req_t          s1_req,    s2_req;
    logic              s1_valid,  s2_valid;
    logic              s1_svalid, s2_svalid;
    logic [DATA_W-1:0] s1_rdata,  s2_rdata;

    master_port m1_port (
        .clk (clk), .rstn (rstn),
        .dev_req (m1_req), .dvalid (m1_dvalid),
        .drdata (m1_drdata), .dready (m1_dready),
        .breq (m1_breq), .bgrant (m1_bgrant),
        .mreq (m1_mreq), .mvalid (m1_mvalid),
        .svalid (m1_svalid), .rdata (m1_rdata)
    );

    master_port m2_port (
        .clk (clk), .rstn (rstn),
        .dev_req (m2_req), .dvalid (m2_dvalid),
        .drdata (m2_drdata), .dready (m2_dready),
        .breq (m2_breq), .bgrant (m2_bgrant),
        .mreq (m2_mreq), .mvalid (m2_mvalid),
        .svalid (m2_svalid), .rdata (m2_rdata)
    );

    bus_interconnect bus_inst (
        .clk (clk), .rstn (rstn),
        .m1_breq (m1_breq), .m2_breq (m2_breq),
        .m1_bgrant (m1_bgrant), .m2_bgrant (m2_bgrant),
        .m1_mreq (m1_mreq), .m2_mreq (m2_mreq),
        .m1_mvalid (m1_mvalid), .m2_mvalid (m2_mvalid),
        .m1_svalid (m1_svalid), .m2_svalid (m2_svalid),
        .m1_rdata (m1_rdata), .m2_rdata (m2_rdata),
        .s1_req (s1_req), .s2_req (s2_req),
        .s1_valid (s1_valid), .s2_valid (s2_valid),
        .s1_svalid (s1_svalid), .s2_svalid (s2_svalid),
        .s1_rdata (s1_rdata), .s2_rdata (s2_rdata)
    );

    // 2 KB at 0x0000
    memory_slave #(.MEM_ADDR_W(S1_ADDR_W)) slave1_inst (
        .clk (clk), .rstn (rstn),
        .sel_req (s1_req), .sel_valid (s1_valid),
        .svalid (s1_svalid), .rdata (s1_rdata)
    );

    // 4 KB at 0x0800
    memory_slave #(.MEM_ADDR_W(S2_ADDR_W)) slave2_inst (
        .clk (clk), .rstn (rstn),
        .sel_req (s2_req), .sel_valid (s2_valid),
        .svalid (s2_svalid), .rdata (s2_rdata)
    );

endmodule

/* design/master_port.sv */
/*
 * Master port between a device and the system bus.
 * A one-cycle dvalid strobe is latched and turned into a bus request.
 * The transfer goes out on the first granted cycle, and the result comes
 * back to the device with a one-cycle dready. Strobes while busy are ignored.
 */

`timescale 1ns/1ns

module master_port import bus_pkg::*; (
    input  logic              clk,
    input  logic              rstn,
    // Device side
    input  bus_req_t          dev_req,
    input  logic              dvalid,
    output logic [DATA_W-1:0] drdata,
    output logic              dready,
    // Bus side
    output logic              breq,
    input  logic              bgrant,
    output bus_req_t          mreq,
    output logic              mvalid,
    input  logic              svalid,
    input  logic [DATA_W-1:0] rdata
);

    logic busy;      // Request outstanding
    logic accept;    // New strobe taken this cycle
    logic complete;  // Slave answered our transfer

    // breq low while busy means the transfer is already out
    assign accept   = dvalid && !busy;
    assign complete = busy && !breq && svalid;

    // --------------------
    // Control
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy   <= 1'b0;
            breq   <= 1'b0;
            mvalid <= 1'b0;
            dready <= 1'b0;
        end else begin
            mvalid <= 1'b0;         // Both are single-cycle pulses
            dready <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
                breq <= 1'b1;       // Held until granted
            end else if (busy && breq && bgrant) begin
                // First granted cycle issues and lets go of the request
                breq   <= 1'b0;
                mvalid <= 1'b1;
            end else if (complete) begin
                busy   <= 1'b0;
                dready <= 1'b1;
            end
        end
    end

    // --------------------
    // Payload
    always_ff @(posedge clk) begin
        if (accept) begin
            mreq <= dev_req;        // Stays stable for the whole transfer
        end
        if (complete) begin
            drdata <= rdata;        // Only meaningful for reads
        end
    end

endmodule

/* design/memory_slave.sv */
/*
 * Byte-wide synchronous memory slave.
 * Depth is 2**MEM_ADDR_W, indexed by the low address bits of sel_req.
 * A write stores the byte, a read registers it. Either way svalid
 * pulses one cycle after sel_valid.
 */

`timescale 1ns/1ns

module memory_slave import bus_pkg::*; #(
    parameter int MEM_ADDR_W = S1_ADDR_W
) (
    input  logic              clk,
    input  logic              rstn,
    input  bus_req_t          sel_req,
    input  logic              sel_valid,
    output logic              svalid,
    output logic [DATA_W-1:0] rdata
);

    logic [DATA_W-1:0]     mem [2**MEM_ADDR_W];
    logic [MEM_ADDR_W-1:0] idx;

    assign idx = sel_req.addr[MEM_ADDR_W-1:0];  // Offset already local

    // Byte storage and registered read data
    always_ff @(posedge clk) begin
        if (sel_valid) begin
            if (sel_req.mode == MODE_WRITE) begin
                mem[idx] <= sel_req.wdata;
            end else begin
                rdata <= mem[idx];
            end
        end
    end

    // One-cycle response strobe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            svalid <= 1'b0;
        end else begin
            svalid <= sel_valid;
        end
    end

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build the bus testbench with Verilator, run it and decide from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module bus_system_tb -f src.f \
    && ./obj_dir/Vbus_system_tb | tee sim.log \
    && grep -qx "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* src.f */
design/bus_pkg.sv
design/master_port.sv
design/bus_arbiter.sv
design/bus_interconnect.sv
design/memory_slave.sv
design/bus_system_top.sv
testbench/tb_clock_gen.sv
testbench/bus_system_tb.sv

/* testbench/bus_system_tb.sv */
/*
 * Testbench for the two-master system bus. Plays both devices, keeps a
 * reference model of the address map and checks every completed read.
 * Also watches the grant lines and the outputs around reset.
 */

`timescale 1ns/1ns

module bus_system_tb import bus_pkg::*; ();

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_RANDOM  = 200;
    localparam int NUM_REQ     = 13 + NUM_RANDOM;   // Directed plus random
    localparam int MAX_WAIT    = 40;                // Cycles per transfer
    localparam int WATCHDOG_NS = NUM_REQ * MAX_WAIT * CLK_PERIOD;

    // Completed transfer as the device saw it
    typedef struct packed {
        logic [1:0]        master;
        bus_req_t          req;
        logic [DATA_W-1:0] rdata;
    } done_t;

    logic              clk, rstn;
    bus_req_t          m1_req, m2_req;
    logic              m1_dvalid, m2_dvalid, m1_dready, m2_dready;
    logic              m1_bgrant, m2_bgrant;
    logic [DATA_W-1:0] m1_drdata, m2_drdata;
    done_t             done_q[$];
    logic [DATA_W-1:0] ref_mem [65536];    // Whole 64 KB space
    bit                written [65536];
    int                err_main  = 0;      // Directed checks and timeouts
    int                err_check = 0;
    int                err_grant = 0;
    int                checked   = 0;

    tb_clock_gen #(.PERIOD(CLK_PERIOD), .RST_CYCLES(4)) clk_gen_inst (.clk(clk), .rstn(rstn));

    bus_system_top bus_system_top_inst (
        .clk (clk), .rstn (rstn),
        .m1_req (m1_req), .m2_req (m2_req),
        .m1_dvalid (m1_dvalid), .m2_dvalid (m2_dvalid),
        .m1_drdata (m1_drdata), .m2_drdata (m2_drdata),
        .m1_dready (m1_dready), .m2_dready (m2_dready),
        .m1_bgrant (m1_bgrant), .m2_bgrant (m2_bgrant)
    );

    // --------------------
    // Reference model
    // Contiguous map from 0 means the bus address is the location
    function automatic logic [DATA_W-1:0] ref_access(input bus_req_t req, output bit known);
        logic mapped;
        mapped     = (req.addr < S2_BASE) || (req.addr <= S2_LIMIT);
        known      = 1'b1;
        ref_access = '0;                    // Unmapped reads give zero
        if (mapped && req.mode == MODE_WRITE) begin
            ref_mem[req.addr] = req.wdata;
            written[req.addr] = 1'b1;
        end else if (mapped) begin
            ref_access = ref_mem[req.addr];
            known      = written[req.addr]; // Nothing to expect if never written
        end
    endfunction

    function automatic int total_errors();
        return err_main + err_check + err_grant;
    endfunction

    // One device request on master m that returns at the negedge seeing dready
    task automatic transfer(input int m, input bus_mode_e mode, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata, output time t_done);
        bus_req_t req;
        done_t    rec;
        int       waited;
        logic     seen;
        req.addr  = addr;
        req.wdata = wdata;
        req.mode  = mode;
        @(posedge clk);
        if (m == 1) begin
            m1_req    <= req;
            m1_dvalid <= 1'b1;
        end else begin
            m2_req    <= req;
            m2_dvalid <= 1'b1;
        end
        @(posedge clk);
        if (m == 1) m1_dvalid <= 1'b0;   // Single-cycle strobe
        else        m2_dvalid <= 1'b0;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < MAX_WAIT) begin
            @(negedge clk);
            seen   = (m == 1) ? m1_dready : m2_dready;
            waited = waited + 1;
        end
        t_done = $time;
        if (!seen) begin
            $display("Master %0d got no dready within %0d cycles, addr 0x%04h", m, MAX_WAIT, addr);
            err_main++;
        end else begin
            rec.master = 2'(m);
            rec.req    = req;
            rec.rdata  = (m == 1) ? m1_drdata : m2_drdata;
            done_q.push_back(rec);
        end
    endtask

    task automatic check_low(input string name, input logic value);
        assert (value === 1'b0) else begin
            $display("MISMATCH %s got=0x%0h exp=0x0", name, value);
            err_main++;
        end
    endtask

    task automatic check_idle();
        check_low("m1_dready", m1_dready);
        check_low("m2_dready", m2_dready);
        check_low("m1_bgrant", m1_bgrant);
        check_low("m2_bgrant", m2_bgrant);
    endtask

    // Drains the comparing process and prints one line for the test
    task automatic finish_test(input string name, input int err_before);
        int new_err;
        @(negedge clk);
        while (done_q.size() != 0) @(negedge clk);
        new_err = total_errors() - err_before;
        if (new_err == 0) $display("Test %s: ok", name);
        else              $display("Test %s: FAILED with %0d errors", name, new_err);
    endtask

    // --------------------
    // Comparing process
    always @(negedge clk) begin
        done_t             rec;
        logic [DATA_W-1:0] exp;
        bit                known;
        while (done_q.size() != 0) begin
            rec = done_q.pop_front();
            exp = ref_access(rec.req, known);
            if (rec.req.mode == MODE_READ && known) begin
                checked++;
                assert (rec.rdata === exp) else begin
                    $display("MISMATCH m%0d_drdata addr=0x%04h got=0x%02h exp=0x%02h",
                             rec.master, rec.req.addr, rec.rdata, exp);
                    err_check++;
                end
            end
        end
    end

    // Grants are exclusive
    always @(negedge clk) begin
        if (rstn) begin
            assert (!(m1_bgrant && m2_bgrant)) else begin
                $display("Both bus grants high at %0t ns", $time);
                err_grant++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests were done");
        $display("Finished with errors");
        $finish;
    end

    // --------------------
    // Stimulus
    initial begin
        time               t1;
        time               t2;
        int                mark;
        logic [31:0]       r;
        logic [ADDR_W-1:0] regions [4];
        bus_req_t          rq;
        bus_req_t          m1_rnd[$];
        bus_req_t          m2_rnd[$];
        regions   = '{16'h0000, 16'h07E0, 16'h17E0, 16'h2000};  // Around map edges
        void'($urandom(32'hd9bc_78e6));
        m1_req    = '0;
        m2_req    = '0;
        m1_dvalid = 1'b0;
        m2_dvalid = 1'b0;

        mark = total_errors();
        do begin
            @(negedge clk);
            check_idle();
        end while (!rstn);
        repeat (2) begin
            @(negedge clk);
            check_idle();
        end
        finish_test("reset state", mark);

        mark = total_errors();
        transfer(1, MODE_WRITE, 16'h0010, 8'hA5, t1);
        transfer(1, MODE_READ,  16'h0010, 8'h00, t1);
        finish_test("master 1 write and read back", mark);

        mark = total_errors();
        transfer(2, MODE_WRITE, 16'h0820, 8'h5A, t1);
        transfer(2, MODE_READ,  16'h0820, 8'h00, t1);
        transfer(1, MODE_READ,  16'h0820, 8'h00, t1);  // Same slave 2 byte
        finish_test("shared slave 2", mark);

        mark = total_errors();
        for (int pass = 0; pass < 2; pass++) begin
            fork
                transfer(1, pass == 0 ? MODE_WRITE : MODE_READ, 16'h0000, 8'h3C, t1);
                transfer(2, pass == 0 ? MODE_WRITE : MODE_READ, 16'h1000, 8'hC3, t2);
            join
            assert (t1 <= t2) else begin
                $display("Master 1 finished after master 2 on a tied request");
                err_main++;
            end
        end
        finish_test("simultaneous requests", mark);

        mark = total_errors();
        transfer(2, MODE_WRITE, 16'h2000, 8'h77, t1);   // Aliases nothing
        transfer(1, MODE_READ,  16'h2000, 8'h00, t1);
        transfer(2, MODE_READ,  16'h0000, 8'h00, t1);
        transfer(1, MODE_READ,  16'h1000, 8'h00, t1);
        finish_test("unmapped address", mark);

        mark = total_errors();
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r        = $urandom;
            rq.addr  = regions[r[3:2]] + {10'b0, r[9:4]};
            rq.wdata = r[17:10];
            rq.mode  = r[1] ? MODE_WRITE : MODE_READ;
            if (r[0]) begin
                m2_rnd.push_back(rq);   // Random master
            end else begin
                m1_rnd.push_back(rq);
            end
        end
        // Both masters at once, each one request at a time
        fork
            foreach (m1_rnd[i]) begin
                transfer(1, m1_rnd[i].mode, m1_rnd[i].addr, m1_rnd[i].wdata, t1);
            end
            foreach (m2_rnd[j]) begin
                transfer(2, m2_rnd[j].mode, m2_rnd[j].addr, m2_rnd[j].wdata, t2);
            end
        join
        finish_test("random transfers", mark);

        $display("Summary: 6 tests, %0d reads checked, %0d errors", checked, total_errors());
        if (total_errors() == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/tb_clock_gen.sv */
/*
 * Clock and reset source for the bus testbench.
 * Free-running clk, rstn held low for RST_CYCLES rising edges.
 */

`timescale 1ns/1ns

module tb_clock_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 4
) (
    output logic clk,
    output logic rstn
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rstn = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        rstn <= 1'b1;   // Released on a rising edge
    end

endmodule
